//--- build.f
+incdir+rtl
rtl/mem_subsys_pkg.sv
rtl/wb_sram.sv
rtl/dual_ram.sv
rtl/wb_interconnect.sv
rtl/mem_subsys_top.sv
verification/mem_subsys_assertions.sv
verification/mem_subsys_tb.sv

//--- rtl/dual_ram.sv
// True dual-port byte-write data RAM, Wishbone slave on port A, native port B
`timescale 1ns/1ps
`include "mem_subsys_params.svh"

module dual_ram (
  input  logic                       clk,
  input  logic                       rst_n_i,
  // Port A, Wishbone classic
  input  mem_subsys_pkg::wb_req_t    a_req_i,
  output mem_subsys_pkg::wb_rsp_t    a_rsp_o,
  // Port B, native data port
  input  mem_subsys_pkg::dport_req_t b_req_i,
  output mem_subsys_pkg::word_t      b_rdata_o
);

  // Word index width for the RAM depth
  localparam int RAM_AW = $clog2(`MEM_RAM_WORDS);

  // ----------------------------------------------------------------------
  // Storage, index decode
  // ----------------------------------------------------------------------

  mem_subsys_pkg::word_t mem [`MEM_RAM_WORDS];

  logic [31:0]           a_offs;
  logic [RAM_AW-1:0]     a_idx;
  logic [RAM_AW-1:0]     b_idx;
  logic                  a_accept;
  logic                  a_wr;
  logic                  ack_q;
  mem_subsys_pkg::word_t a_rdata_q;
  mem_subsys_pkg::word_t b_rdata_q;

  // Port A sees the RAM through the data window, strip the base first
  assign a_offs = a_req_i.adr - `MEM_RAM_BASE;
  assign a_idx  = a_offs[RAM_AW+1:2];

  // Port B addresses the RAM from word 0
  assign b_idx  = b_req_i.addr[RAM_AW+1:2];

  // Same accept rule as every other slave
  assign a_accept = a_req_i.cyc & a_req_i.stb & ~ack_q;
  assign a_wr     = a_accept & a_req_i.we;

  // ----------------------------------------------------------------------
  // Array writes, both ports
  // ----------------------------------------------------------------------

  // Port B assignments come last, so on a same-word collision its
  // enabled bytes override port A and the other bytes keep port A data
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (a_wr && a_req_i.sel[b]) begin
        mem[a_idx][b*8 +: 8] <= a_req_i.dat[b*8 +: 8];
      end
      if (b_req_i.en && b_req_i.we[b]) begin
        mem[b_idx][b*8 +: 8] <= b_req_i.din[b*8 +: 8];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Port A read and handshake
  // ----------------------------------------------------------------------

  // Payload register, old contents on a read-during-write
  always_ff @(posedge clk) begin
    if (a_accept) begin
      a_rdata_q <= mem[a_idx];
    end
  end

  // Single-cycle ack one edge after acceptance
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= a_accept;
    end
  end

  assign a_rsp_o.ack = ack_q;
  assign a_rsp_o.err = 1'b0;
  assign a_rsp_o.dat = a_rdata_q;

  // ----------------------------------------------------------------------
  // Port B read
  // ----------------------------------------------------------------------

  // Registered read, held between enables
  // Cleared by reset so the port idles at zero
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      b_rdata_q <= '0;
    end else if (b_req_i.en) begin
      b_rdata_q <= mem[b_idx];
    end
  end

  assign b_rdata_o = b_rdata_q;

endmodule

//--- rtl/mem_subsys_params.svh
// Memory depths and address window bounds for the memory subsystem
`ifndef MEM_SUBSYS_PARAMS_SVH
`define MEM_SUBSYS_PARAMS_SVH

// ----------------------------------------------------------------------
// Memory depths, in 32-bit words
// ----------------------------------------------------------------------

// Instruction SRAM depth
`define MEM_ROM_WORDS 16

// Data RAM depth, shared by both ports
`define MEM_RAM_WORDS 32

// ----------------------------------------------------------------------
// Address windows seen by the Wishbone master (inclusive byte bounds)
// ----------------------------------------------------------------------

// Instruction SRAM window
`define MEM_ROM_BASE 32'h0000_0000
`define MEM_ROM_LAST 32'h0000_003f

// Data RAM window, port A
`define MEM_RAM_BASE 32'h0000_0040
`define MEM_RAM_LAST 32'h0000_007f

`endif

//--- rtl/mem_subsys_pkg.sv
// Word, byte-enable, Wishbone request/response and data-port request types
package mem_subsys_pkg;

  // ----------------------------------------------------------------------
  // Basic data types
  // ----------------------------------------------------------------------

  // One memory word, every memory in the subsystem uses this width
  typedef logic [31:0] word_t;

  // One enable per byte lane of word_t
  typedef logic [3:0] sel_t;

  // ----------------------------------------------------------------------
  // Wishbone classic bundles
  // ----------------------------------------------------------------------

  // Master to slave, 71 bits
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;  // byte address
    sel_t        sel;
    word_t       dat;  // write data
  } wb_req_t;

  // Slave to master, 34 bits
  typedef struct packed {
    logic  ack;
    logic  err;
    word_t dat;        // read data, valid with ack
  } wb_rsp_t;

  // ----------------------------------------------------------------------
  // Native data port
  // ----------------------------------------------------------------------

  // Plain enable plus per-byte write strobes, 69 bits
  typedef struct packed {
    logic        en;
    sel_t        we;   // all zero means read
    logic [31:0] addr; // byte address, word 0 at address 0
    word_t       din;
  } dport_req_t;

endpackage

//--- rtl/mem_subsys_top.sv
// Memory subsystem top level, interconnect plus instruction SRAM and data RAM
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic                       clk,
  input  logic                       rst_n_i,
  // Instruction fetch port, Wishbone classic master side
  input  mem_subsys_pkg::wb_req_t    wbm_req_i,
  output mem_subsys_pkg::wb_rsp_t    wbm_rsp_o,
  // Native data port into data RAM port B
  input  mem_subsys_pkg::dport_req_t dport_req_i,
  output mem_subsys_pkg::word_t      dport_rdata_o
);

  // ----------------------------------------------------------------------
  // Interconnect to slave links
  // ----------------------------------------------------------------------

  mem_subsys_pkg::wb_req_t rom_req;
  mem_subsys_pkg::wb_rsp_t rom_rsp;
  mem_subsys_pkg::wb_req_t ram_req;
  mem_subsys_pkg::wb_rsp_t ram_rsp;

  // Address decode and response merge
  wb_interconnect u_intercon (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .m_req_i   ( wbm_req_i ),
    .m_rsp_o   ( wbm_rsp_o ),
    .rom_req_o ( rom_req   ),
    .rom_rsp_i ( rom_rsp   ),
    .ram_req_o ( ram_req   ),
    .ram_rsp_i ( ram_rsp   )
  );

  // Instruction memory, window 0x00 to 0x3f
  wb_sram u_rom (
    .clk     ( clk     ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( rom_req ),
    .rsp_o   ( rom_rsp )
  );

  // Data memory, port A through window 0x40 to 0x7f
  // Port B driven directly by the data port
  dual_ram u_ram (
    .clk       ( clk           ),
    .rst_n_i   ( rst_n_i       ),
    .a_req_i   ( ram_req       ),
    .a_rsp_o   ( ram_rsp       ),
    .b_req_i   ( dport_req_i   ),
    .b_rdata_o ( dport_rdata_o )
  );

endmodule

//--- rtl/wb_interconnect.sv
// Wishbone address decoder, request router, response combiner and error slave
`timescale 1ns/1ps
`include "mem_subsys_params.svh"

module wb_interconnect (
  input  logic                    clk,
  input  logic                    rst_n_i,
  // Master side
  input  mem_subsys_pkg::wb_req_t m_req_i,
  output mem_subsys_pkg::wb_rsp_t m_rsp_o,
  // Instruction SRAM slave
  output mem_subsys_pkg::wb_req_t rom_req_o,
  input  mem_subsys_pkg::wb_rsp_t rom_rsp_i,
  // Data RAM slave, port A
  output mem_subsys_pkg::wb_req_t ram_req_o,
  input  mem_subsys_pkg::wb_rsp_t ram_rsp_i
);

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------

  logic rom_hit;
  logic ram_hit;
  logic unmapped;
  logic err_q;

  // Inclusive bounds on both ends
  assign rom_hit = (m_req_i.adr >= `MEM_ROM_BASE) && (m_req_i.adr <= `MEM_ROM_LAST);
  assign ram_hit = (m_req_i.adr >= `MEM_RAM_BASE) && (m_req_i.adr <= `MEM_RAM_LAST);

  // Live request that no slave claims
  assign unmapped = m_req_i.cyc & m_req_i.stb & ~rom_hit & ~ram_hit;

  // ----------------------------------------------------------------------
  // Request routing
  // ----------------------------------------------------------------------

  // Both slaves see the full request, stb only reaches the selected one
  always_comb begin
    rom_req_o     = m_req_i;
    rom_req_o.stb = m_req_i.stb & rom_hit;
  end

  always_comb begin
    ram_req_o     = m_req_i;
    ram_req_o.stb = m_req_i.stb & ram_hit;
  end

  // ----------------------------------------------------------------------
  // Unmapped error
  // ----------------------------------------------------------------------

  // One-cycle err pulse, the held request does not retrigger it
  // during the err cycle itself
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= unmapped & ~err_q;
    end
  end

  // ----------------------------------------------------------------------
  // Response combining
  // ----------------------------------------------------------------------

  // At most one slave acks per cycle since stb is exclusive
  always_comb begin
    m_rsp_o.ack = rom_rsp_i.ack | ram_rsp_i.ack;
    m_rsp_o.err = rom_rsp_i.err | ram_rsp_i.err | err_q;
    // Data follows the acking slave, zero otherwise (also on err)
    if (rom_rsp_i.ack) begin
      m_rsp_o.dat = rom_rsp_i.dat;
    end else if (ram_rsp_i.ack) begin
      m_rsp_o.dat = ram_rsp_i.dat;
    end else begin
      m_rsp_o.dat = '0;
    end
  end

endmodule

//--- rtl/wb_sram.sv
// Wishbone classic slave with a single-port byte-enable SRAM for instructions
`timescale 1ns/1ps
`include "mem_subsys_params.svh"

module wb_sram (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  mem_subsys_pkg::wb_req_t  req_i,
  output mem_subsys_pkg::wb_rsp_t  rsp_o
);

  // Word index width for the SRAM depth
  localparam int ROM_AW = $clog2(`MEM_ROM_WORDS);

  // ----------------------------------------------------------------------
  // Storage and response registers
  // ----------------------------------------------------------------------

  mem_subsys_pkg::word_t mem [`MEM_ROM_WORDS];

  logic                  ack_q;
  mem_subsys_pkg::word_t rdata_q;
  logic                  accept;
  logic [ROM_AW-1:0]     idx;

  // New access only when not already acking this one
  assign accept = req_i.cyc & req_i.stb & ~ack_q;

  // Window is chosen upstream, so only the word index bits matter here
  assign idx = req_i.adr[ROM_AW+1:2];

  // ----------------------------------------------------------------------
  // Array write and read
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      // Read data captured before any write of this cycle lands
      rdata_q <= mem[idx];
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          // Only enabled byte lanes are replaced
          if (req_i.sel[b]) begin
            mem[idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------

  // Ack is a single-cycle pulse on the edge after acceptance
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  // This slave never signals an error
  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;
  assign rsp_o.dat = rdata_q;

endmodule

//--- verification/mem_subsys_assertions.sv
// Concurrent Wishbone protocol checks on the interconnect master side, and their bind
`timescale 1ns/1ps

module mem_subsys_assertions (
  input logic                    clk,
  input logic                    rst_n_i,
  input mem_subsys_pkg::wb_req_t m_req_i,
  input mem_subsys_pkg::wb_rsp_t m_rsp_i
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // ----------------------------------------------------------------------
  // Handshake rules
  // ----------------------------------------------------------------------

  // Ack and err are exclusive
  a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(m_rsp_i.ack && m_rsp_i.err))
    else begin
      $error("ack and err high together");
      fail_count++;
    end

  // Every response answers a live request of the previous cycle
  a_rsp_has_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    (m_rsp_i.ack || m_rsp_i.err) |-> $past(m_req_i.cyc && m_req_i.stb))
    else begin
      $error("response without a request one cycle earlier");
      fail_count++;
    end

  // Single-cycle ack pulse
  a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    m_rsp_i.ack |=> !m_rsp_i.ack)
    else begin
      $error("ack held for two cycles");
      fail_count++;
    end

  // Quiet response while in reset, from the second reset edge on
  a_rst_quiet: assert property (@(posedge clk)
    (!rst_n_i ##1 !rst_n_i) |-> (!m_rsp_i.ack && !m_rsp_i.err))
    else begin
      $error("ack or err during reset");
      fail_count++;
    end

endmodule

bind wb_interconnect mem_subsys_assertions u_wb_checks (
  .clk     ( clk     ),
  .rst_n_i ( rst_n_i ),
  .m_req_i ( m_req_i ),
  .m_rsp_i ( m_rsp_o )
);

//--- verification/mem_subsys_input.txt
# kind addr data sel data_b sel_b expected outcome (hex fields, outcome ack, err or - for port B)
# W/R Wishbone write/read, P/Q port B write/read, C Wishbone and port B write in one cycle
# Instruction window, full words then partial byte writes
W 00000000 11223344 f 00000000 0 00000000 ack
W 00000004 a5a5a5a5 f 00000000 0 00000000 ack
W 0000003c 01020304 f 00000000 0 00000000 ack
W 00000000 deadbeef 5 00000000 0 00000000 ack
W 00000004 cafef00d c 00000000 0 00000000 ack
W 0000003c ffffffff 2 00000000 0 00000000 ack
R 00000000 00000000 0 00000000 0 11ad33ef ack
R 00000004 00000000 0 00000000 0 cafea5a5 ack
R 0000003c 00000000 0 00000000 0 0102ff04 ack
# Port B write, Wishbone read through the data window
P 00000008 87654321 f 00000000 0 00000000 -
R 00000048 00000000 0 00000000 0 87654321 ack
P 0000003c 0badf00d f 00000000 0 00000000 -
R 0000007c 00000000 0 00000000 0 0badf00d ack
# Wishbone write to the data window, port B read
W 00000050 aabbccdd f 00000000 0 00000000 ack
W 00000050 11111111 9 00000000 0 00000000 ack
Q 00000010 00000000 0 00000000 0 11bbcc11 -
P 00000014 ffff0000 f 00000000 0 00000000 -
W 00000054 12345678 6 00000000 0 00000000 ack
Q 00000014 00000000 0 00000000 0 ff345600 -
# Unmapped addresses, then neighbouring words unchanged
W 00000080 ffffffff f 00000000 0 00000000 err
R 00000084 00000000 0 00000000 0 00000000 err
R 00001000 00000000 0 00000000 0 00000000 err
R 0000007c 00000000 0 00000000 0 0badf00d ack
R 0000003c 00000000 0 00000000 0 0102ff04 ack
Q 0000003c 00000000 0 00000000 0 0badf00d -
R 00000000 00000000 0 00000000 0 11ad33ef ack
# Same-cycle writes from both ports to data word 8
C 00000060 a1a2a3a4 f b1b2b3b4 3 00000000 ack
R 00000060 00000000 0 00000000 0 a1a2b3b4 ack
C 00000060 c1c2c3c4 6 d1d2d3d4 c 00000000 ack
R 00000060 00000000 0 00000000 0 d1d2c3b4 ack
Q 00000020 00000000 0 00000000 0 d1d2c3b4 -

//--- verification/mem_subsys_tb.sv
// Testbench for the memory subsystem, file-driven Wishbone and data-port operations
`timescale 1ns/1ps
`include "mem_subsys_params.svh"

module mem_subsys_tb;

  localparam int          WB_TIMEOUT = 10;
  localparam int          MAX_OPS    = 200;
  // Taps of a maximal-length 32-bit Galois LFSR
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

  logic                       clk;
  logic                       rst_n_i;
  mem_subsys_pkg::wb_req_t    wbm_req;
  mem_subsys_pkg::wb_rsp_t    wbm_rsp;
  mem_subsys_pkg::dport_req_t dport_req;
  mem_subsys_pkg::word_t      dport_rdata;
  logic [31:0]                lfsr;

  mem_subsys_top u_dut (
    .clk           ( clk         ),
    .rst_n_i       ( rst_n_i     ),
    .wbm_req_i     ( wbm_req     ),
    .wbm_rsp_o     ( wbm_rsp     ),
    .dport_req_i   ( dport_req   ),
    .dport_rdata_o ( dport_rdata )
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Random gaps, reporting and compare tasks
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) begin
      s = s ^ LFSR_TAPS;
    end
    return s;
  endfunction

  // One LFSR step per bit handed out
  task automatic take_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_step(lfsr);
  endtask

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_wb_rsp(input mem_subsys_pkg::wb_rsp_t got,
                              input mem_subsys_pkg::wb_rsp_t exp,
                              input logic dat_valid, input string name);
    if (got.ack !== exp.ack) begin
      $display("CHECK FAILED time %0t %s.ack expected %0b got %0b",
               $time, name, exp.ack, got.ack);
      abort_run();
    end
    if (got.err !== exp.err) begin
      $display("CHECK FAILED time %0t %s.err expected %0b got %0b",
               $time, name, exp.err, got.err);
      abort_run();
    end
    // Write acks carry stale data, only reads and errors define dat
    if (dat_valid && got.dat !== exp.dat) begin
      $display("CHECK FAILED time %0t %s.dat expected %h got %h",
               $time, name, exp.dat, got.dat);
      abort_run();
    end
  endtask

  task automatic check_word(input mem_subsys_pkg::word_t got,
                            input mem_subsys_pkg::word_t exp, input string name);
    if (got !== exp) begin
      $display("CHECK FAILED time %0t %s expected %h got %h", $time, name, exp, got);
      abort_run();
    end
  endtask

  // Protocol assertion failures in the bound interconnect checker
  always @(u_dut.u_intercon.u_wb_checks.fail_count) begin
    if (u_dut.u_intercon.u_wb_checks.fail_count != 0) begin
      $display("A Wishbone protocol assertion failed on the interconnect");
      abort_run();
    end
  end

  // ----------------------------------------------------------------------
  // Port drivers
  // ----------------------------------------------------------------------

  task automatic drive_wb(input logic we, input logic [31:0] adr,
                          input mem_subsys_pkg::word_t dat, input mem_subsys_pkg::sel_t sel);
    wbm_req.cyc = 1'b1;
    wbm_req.stb = 1'b1;
    wbm_req.we  = we;
    wbm_req.adr = adr;
    wbm_req.sel = sel;
    wbm_req.dat = dat;
  endtask

  task automatic drive_dport(input logic en, input mem_subsys_pkg::sel_t we,
                             input logic [31:0] addr, input mem_subsys_pkg::word_t din);
    dport_req.en   = en;
    dport_req.we   = we;
    dport_req.addr = addr;
    dport_req.din  = din;
  endtask

  // Hold the request until ack or err, then release it in that same cycle
  task automatic complete_wb(input mem_subsys_pkg::wb_rsp_t exp_rsp, input logic dat_valid);
    mem_subsys_pkg::wb_rsp_t got;
    logic                    seen;
    seen = 1'b0;
    for (int n = 0; n < WB_TIMEOUT && !seen; n++) begin
      @(posedge clk);
      #1;
      got  = wbm_rsp;
      seen = (got.ack === 1'b1) || (got.err === 1'b1);
    end
    if (!seen) begin
      $display("Timeout: no ack or err within %0d cycles for address %h",
               WB_TIMEOUT, wbm_req.adr);
      abort_run();
    end
    wbm_req = '0;
    check_wb_rsp(got, exp_rsp, dat_valid, "wbm_rsp_o");
  endtask

  // Outputs that must sit at zero around reset
  task automatic check_idle_outputs();
    check_wb_rsp(wbm_rsp, '0, 1'b1, "wbm_rsp_o");
    check_word(dport_rdata, '0, "dport_rdata_o");
  endtask

  // ----------------------------------------------------------------------
  // One operation from the data file
  // ----------------------------------------------------------------------

  task automatic run_op(input logic [7:0] kind, input logic [31:0] adr,
                        input logic [31:0] dat, input logic [31:0] sel,
                        input logic [31:0] dat_b, input logic [31:0] sel_b,
                        input logic [31:0] exp_dat, input logic [23:0] outcome);
    mem_subsys_pkg::wb_rsp_t exp_rsp;
    logic                    dat_valid;
    exp_rsp.ack = (outcome == "ack");
    exp_rsp.err = (outcome == "err");
    // Error responses carry zero data
    exp_rsp.dat = exp_rsp.err ? '0 : exp_dat;
    dat_valid   = (kind == "R") || exp_rsp.err;
    case (kind)
      "W", "R": begin
        drive_wb(kind == "W", adr, dat, sel[3:0]);
        complete_wb(exp_rsp, dat_valid);
      end
      "P": begin
        drive_dport(1'b1, sel[3:0], adr, dat);
        @(posedge clk);
        #1;
        dport_req = '0;
      end
      "Q": begin
        drive_dport(1'b1, 4'h0, adr, '0);
        @(posedge clk);
        #1;
        check_word(dport_rdata, exp_dat, "dport_rdata_o");
        dport_req = '0;
      end
      "C": begin
        // Port B sees the same word from index 0, without the window base
        drive_wb(1'b1, adr, dat, sel[3:0]);
        drive_dport(1'b1, sel_b[3:0], adr - `MEM_RAM_BASE, dat_b);
        complete_wb(exp_rsp, dat_valid);
        dport_req = '0;
      end
      default: begin
        $display("Unknown operation kind %c in the data file", kind);
        abort_run();
      end
    endcase
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int          fd;
    int          code;
    int          ch;
    int          ops;
    logic        done;
    logic        b0;
    logic        b1;
    logic [7:0]  kind;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] sel;
    logic [31:0] dat_b;
    logic [31:0] sel_b;
    logic [31:0] exp_dat;
    logic [23:0] outcome;
    rst_n_i   = 1'b0;
    wbm_req   = '0;
    dport_req = '0;
    lfsr      = 32'he1998c94;
    ops       = 0;
    done      = 1'b0;
    // Outputs held at zero through reset and one cycle beyond
    repeat (3) begin
      @(posedge clk);
      #1;
      check_idle_outputs();
    end
    rst_n_i = 1'b1;
    @(posedge clk);
    #1;
    check_idle_outputs();
    fd = $fopen("verification/mem_subsys_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the data file verification/mem_subsys_input.txt");
      abort_run();
    end
    while (!done) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) begin
        done = 1'b1;
      end else if (kind == "#") begin
        // Comment line, skip to its end
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        code = $fscanf(fd, " %h %h %h %h %h %h %s", adr, dat, sel, dat_b, sel_b,
                       exp_dat, outcome);
        if (code != 7) begin
          $display("Malformed line in the data file after %0d operations", ops);
          abort_run();
        end
        // Idle gap of 0 to 3 cycles from two LFSR bits
        take_bit(b1);
        take_bit(b0);
        repeat ({b1, b0}) @(posedge clk);
        @(posedge clk);
        #1;
        run_op(kind, adr, dat, sel, dat_b, sel_b, exp_dat, outcome);
        ops++;
        if (ops > MAX_OPS) begin
          $display("Data file holds more than %0d operations", MAX_OPS);
          abort_run();
        end
      end
    end
    $fclose(fd);
    if (ops == 0) begin
      $display("No operation was read from the data file");
      $display("Something failed");
      $fatal(1, "empty stimulus");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule
